// File: Makefile
VERILATOR  ?= verilator
TOP        ?= agen_tb
LOG        ?= sim.log
FIFO_DEPTH ?= 4
OBJ_DIR    ?= obj_dir

SRCS := $(filter %.sv %.v,$(shell cat all.f))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SRCS)
	$(VERILATOR) --binary --timing --assert -f all.f --top-module $(TOP) \
		-GFIFO_DEPTH=$(FIFO_DEPTH) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
src/agen_pkg.sv
src/agen_operand_stage.sv
src/agen_pipe_fifo.sv
src/agen_addr_stage.sv
src/agen_top.sv
tb/agen_checker.sv
tb/agen_sva.sv
tb/agen_tb.sv

// File: src/agen_addr_stage.sv
module agen_addr_stage
   import agen_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,

   input  logic               q_valid,
   output logic               q_ready,
   input  logic [31:0]        q_offset,
   input  logic [31:0]        q_seg_base,
   input  logic [31:0]        q_seg_limit,
   input  logic [BYTES_W-1:0] q_bytes,
   input  logic               q_write,
   input  logic [TAG_W-1:0]   q_tag,

   output logic               res_valid,
   input  logic               res_ready,
   output logic [31:0]        res_addr,
   output logic               res_write,
   output logic               res_seg_fault,
   output logic [TAG_W-1:0]   res_tag
);

   logic [31:0] linear_addr;
   logic [32:0] access_end;
   logic        limit_fault;
   logic        take;

   // Segment base plus offset, wraps at 4G
   assign linear_addr = q_seg_base + q_offset;

   // Last byte touched; bit 32 set means the access ran past 4G
   assign access_end  = {1'b0, q_offset} + 33'(q_bytes) - 33'd1;

   // Catches both limit overrun and wrap since limit has bit 32 clear
   assign limit_fault = access_end > {1'b0, q_seg_limit};

   // Result register, drains when the consumer takes it
   assign q_ready = !res_valid || res_ready;
   assign take    = q_valid && q_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         res_valid <= 1'b0;
      else if (take)
         res_valid <= 1'b1;
      else if (res_ready)
         res_valid <= 1'b0;
   end

   // Faulting accesses still carry their address
   always_ff @(posedge clk) begin
      if (take) begin
         res_addr      <= linear_addr;
         res_write     <= q_write;
         res_seg_fault <= limit_fault;
         res_tag       <= q_tag;
      end
   end

endmodule

// File: src/agen_operand_stage.sv
module agen_operand_stage
   import agen_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,

   input  logic                 seg_wr_en,
   input  logic [SEG_IDX_W-1:0] seg_wr_idx,
   input  logic [31:0]          seg_wr_base,
   input  logic [31:0]          seg_wr_limit,

   input  logic                 req_valid,
   output logic                 req_ready,
   input  agen_uop_u            req_uop,
   input  logic [TAG_W-1:0]     req_tag,
   input  logic [31:0]          req_base,
   input  logic [31:0]          req_index,
   input  logic [31:0]          req_disp,

   output logic                 op_valid,
   input  logic                 op_ready,
   output logic [31:0]          op_offset,
   output logic [31:0]          op_seg_base,
   output logic [31:0]          op_seg_limit,
   output logic [BYTES_W-1:0]   op_bytes,
   output logic                 op_write,
   output logic [TAG_W-1:0]     op_tag
);

   logic [31:0]          seg_base  [NUM_SEGS];
   logic [31:0]          seg_limit [NUM_SEGS];

   logic [BYTES_W-1:0]   bytes;
   logic [31:0]          scaled_index;
   logic [31:0]          offset;
   logic [SEG_IDX_W-1:0] seg_sel;
   logic                 write;
   logic                 accept;

   // Segment table, flat 4G segments out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_SEGS; i++) begin
            seg_base[i]  <= '0;
            seg_limit[i] <= '1;
         end
      end else if (seg_wr_en) begin
         seg_base[seg_wr_idx]  <= seg_wr_base;
         seg_limit[seg_wr_idx] <= seg_wr_limit;
      end
   end

   // Decode by kind bit, same position in both views
   always_comb begin
      scaled_index = '0;
      if (req_uop.stk.kind) begin
         bytes   = size_bytes(req_uop.stk.size);
         seg_sel = SEG_SS;
         write   = req_uop.stk.push;
         // Push pre-decrements SP, pop reads at SP
         offset  = req_uop.stk.push ? req_base - 32'(bytes) : req_base;
      end else begin
         bytes   = size_bytes(req_uop.mem.size);
         seg_sel = req_uop.mem.seg;
         write   = req_uop.mem.write;
         if (req_uop.mem.idx_valid)
            scaled_index = req_index << req_uop.mem.scale;
         offset  = req_base + req_disp + scaled_index;
      end
   end

   // One-entry output register
   assign req_ready = !op_valid || op_ready;
   assign accept    = req_valid && req_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         op_valid <= 1'b0;
      else if (accept)
         op_valid <= 1'b1;
      else if (op_ready)
         op_valid <= 1'b0;
   end

   // Table read sees contents before any write on this edge
   always_ff @(posedge clk) begin
      if (accept) begin
         op_offset    <= offset;
         op_seg_base  <= seg_base[seg_sel];
         op_seg_limit <= seg_limit[seg_sel];
         op_bytes     <= bytes;
         op_write     <= write;
         op_tag       <= req_tag;
      end
   end

endmodule

// File: src/agen_pipe_fifo.sv
module agen_pipe_fifo
   import agen_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic               clk,
   input  logic               arst_n,

   input  logic               op_valid,
   output logic               op_ready,
   input  logic [31:0]        op_offset,
   input  logic [31:0]        op_seg_base,
   input  logic [31:0]        op_seg_limit,
   input  logic [BYTES_W-1:0] op_bytes,
   input  logic               op_write,
   input  logic [TAG_W-1:0]   op_tag,

   output logic               q_valid,
   input  logic               q_ready,
   output logic [31:0]        q_offset,
   output logic [31:0]        q_seg_base,
   output logic [31:0]        q_seg_limit,
   output logic [BYTES_W-1:0] q_bytes,
   output logic               q_write,
   output logic [TAG_W-1:0]   q_tag
);

   localparam int PTR_W   = $clog2(FIFO_DEPTH);
   localparam int ENTRY_W = 3 * 32 + BYTES_W + 1 + TAG_W;
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

   logic [ENTRY_W-1:0] fifo_mem [FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W:0]     count;
   logic               push;
   logic               pop;

   // No bypass, so both flags follow the count alone
   assign op_ready = count != FULL_CNT;
   assign q_valid  = count != '0;
   assign push     = op_valid && op_ready;
   assign pop      = q_valid && q_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap on their own, depth is a power of two
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         fifo_mem[wr_ptr] <= {op_offset, op_seg_base, op_seg_limit, op_bytes, op_write, op_tag};
   end

   assign {q_offset, q_seg_base, q_seg_limit, q_bytes, q_write, q_tag} = fifo_mem[rd_ptr];

endmodule

// File: src/agen_pkg.sv
package agen_pkg;

   // Segment table geometry
   localparam int NUM_SEGS  = 8;
   localparam int SEG_IDX_W = $clog2(NUM_SEGS);

   // Stack accesses always go through SS
   localparam logic [SEG_IDX_W-1:0] SEG_SS = 3'd2;

   // Result tag and byte count widths
   localparam int TAG_W   = 4;
   localparam int BYTES_W = 3;

   // Memory form of the micro-op, kind bit clear
   typedef struct packed {
      logic                 kind;
      logic [SEG_IDX_W-1:0] seg;
      logic [1:0]           scale;
      logic [1:0]           size;
      logic                 write;
      logic                 idx_valid;
      logic [21:0]          rsvd;
   } agen_mem_view_t;

   // Stack form, kind bit set
   typedef struct packed {
      logic                 kind;
      logic                 push;
      logic [1:0]           size;
      logic [27:0]          rsvd;
   } agen_stack_view_t;

   typedef union packed {
      agen_mem_view_t   mem;
      agen_stack_view_t stk;
   } agen_uop_u;

   // Size code 0/1/2 gives 1/2/4 bytes; code 3 is taken as a dword too
   function automatic logic [BYTES_W-1:0] size_bytes(input logic [1:0] code);
      case (code)
         2'd0:    return 3'd1;
         2'd1:    return 3'd2;
         default: return 3'd4;
      endcase
   endfunction

endpackage

// File: src/agen_top.sv
module agen_top
   import agen_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 arst_n,

   input  logic                 seg_wr_en,
   input  logic [SEG_IDX_W-1:0] seg_wr_idx,
   input  logic [31:0]          seg_wr_base,
   input  logic [31:0]          seg_wr_limit,

   input  logic                 req_valid,
   output logic                 req_ready,
   input  agen_uop_u            req_uop,
   input  logic [TAG_W-1:0]     req_tag,
   input  logic [31:0]          req_base,
   input  logic [31:0]          req_index,
   input  logic [31:0]          req_disp,

   output logic                 res_valid,
   input  logic                 res_ready,
   output logic [31:0]          res_addr,
   output logic                 res_write,
   output logic                 res_seg_fault,
   output logic [TAG_W-1:0]     res_tag
);

   // Operand stage to FIFO
   logic               op_valid;
   logic               op_ready;
   logic [31:0]        op_offset;
   logic [31:0]        op_seg_base;
   logic [31:0]        op_seg_limit;
   logic [BYTES_W-1:0] op_bytes;
   logic               op_write;
   logic [TAG_W-1:0]   op_tag;

   // FIFO to address stage
   logic               q_valid;
   logic               q_ready;
   logic [31:0]        q_offset;
   logic [31:0]        q_seg_base;
   logic [31:0]        q_seg_limit;
   logic [BYTES_W-1:0] q_bytes;
   logic               q_write;
   logic [TAG_W-1:0]   q_tag;

   agen_operand_stage u_operand (
      .clk, .arst_n,
      .seg_wr_en, .seg_wr_idx, .seg_wr_base, .seg_wr_limit,
      .req_valid, .req_ready, .req_uop, .req_tag, .req_base, .req_index, .req_disp,
      .op_valid, .op_ready, .op_offset, .op_seg_base, .op_seg_limit,
      .op_bytes, .op_write, .op_tag
   );

   agen_pipe_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk, .arst_n,
      .op_valid, .op_ready, .op_offset, .op_seg_base, .op_seg_limit,
      .op_bytes, .op_write, .op_tag,
      .q_valid, .q_ready, .q_offset, .q_seg_base, .q_seg_limit,
      .q_bytes, .q_write, .q_tag
   );

   agen_addr_stage u_addr (
      .clk, .arst_n,
      .q_valid, .q_ready, .q_offset, .q_seg_base, .q_seg_limit,
      .q_bytes, .q_write, .q_tag,
      .res_valid, .res_ready, .res_addr, .res_write, .res_seg_fault, .res_tag
   );

endmodule

// File: tb/agen_checker.sv
module agen_checker
   import agen_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,

   input  logic             exp_push,
   input  logic [31:0]      exp_addr,
   input  logic             exp_write,
   input  logic             exp_fault,
   input  logic [TAG_W-1:0] exp_tag,

   input  logic             res_valid,
   input  logic             res_ready,
   input  logic [31:0]      res_addr,
   input  logic             res_write,
   input  logic             res_seg_fault,
   input  logic [TAG_W-1:0] res_tag,

   output int               pending,
   output int               mismatches,
   output int               other_errs
);
   timeunit 1ns;
   timeprecision 100ps;

   // Expected results in request order, packed as addr, write, fault, tag
   logic [32+1+1+TAG_W-1:0] exp_q [$];
   logic [31:0]             e_addr;
   logic                    e_write;
   logic                    e_fault;
   logic [TAG_W-1:0]        e_tag;
   int                      pending_cnt = 0;
   int                      mism_cnt    = 0;
   int                      other_cnt   = 0;

   assign pending    = pending_cnt;
   assign mismatches = mism_cnt;
   assign other_errs = other_cnt;

   task automatic check_field(input string name, input logic [TAG_W-1:0] tag,
                              input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("Mismatch at %0t ns: tag %0h %s got %0h expected %0h",
                  $time, tag, name, got, want);
         mism_cnt++;
      end
   endtask

   always @(posedge clk) begin
      if (exp_push)
         exp_q.push_back({exp_addr, exp_write, exp_fault, exp_tag});
      // One result leaves per transfer edge
      if (arst_n && res_valid && res_ready) begin
         if (exp_q.size() == 0) begin
            $display("Result with tag %0h arrived at %0t ns when no result was expected",
                     res_tag, $time);
            other_cnt++;
         end else begin
            {e_addr, e_write, e_fault, e_tag} = exp_q.pop_front();
            check_field("tag", e_tag, 32'(res_tag), 32'(e_tag));
            check_field("address", e_tag, res_addr, e_addr);
            check_field("write flag", e_tag, 32'(res_write), 32'(e_write));
            check_field("fault flag", e_tag, 32'(res_seg_fault), 32'(e_fault));
         end
      end
      pending_cnt = exp_q.size();
   end

endmodule

// File: tb/agen_sva.sv
module agen_sva
   import agen_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             req_valid,
   input  logic             req_ready,
   input  logic [31:0]      req_uop,
   input  logic [TAG_W-1:0] req_tag,
   input  logic [31:0]      req_base,
   input  logic [31:0]      req_index,
   input  logic [31:0]      req_disp,
   input  logic             res_valid,
   input  logic             res_ready,
   input  logic [31:0]      res_addr,
   input  logic             res_write,
   input  logic             res_seg_fault,
   input  logic [TAG_W-1:0] res_tag
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;

   // Request must hold until the operand stage takes it
   req_held: assert property (@(posedge clk) disable iff (!arst_n)
      req_valid && !req_ready |=> req_valid &&
         $stable({req_uop, req_tag, req_base, req_index, req_disp}))
      else begin
         $error("request valid dropped or data changed before acceptance");
         fail_cnt++;
      end

   res_held: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> res_valid &&
         $stable({res_addr, res_write, res_seg_fault, res_tag}))
      else begin
         $error("result valid dropped or data changed before it was taken");
         fail_cnt++;
      end

   res_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !res_valid)
      else begin
         $error("res_valid high while reset is asserted");
         fail_cnt++;
      end

   // First edge out of reset, pipeline is empty
   ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> req_ready)
      else begin
         $error("req_ready low in the first cycle after reset");
         fail_cnt++;
      end

endmodule

bind agen_top agen_sva sva_i (
   .clk, .arst_n,
   .req_valid, .req_ready, .req_uop, .req_tag, .req_base, .req_index, .req_disp,
   .res_valid, .res_ready, .res_addr, .res_write, .res_seg_fault, .res_tag
);

// File: tb/agen_tb.sv
module agen_tb
   import agen_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RAND_SEED  = 31832;
   localparam int RESET_CYC  = 16;
   localparam int CLK_PERIOD = 40;

   logic                 clk          = 1'b0;
   logic                 arst_n       = 1'b0;
   logic                 seg_wr_en    = 1'b0;
   logic [SEG_IDX_W-1:0] seg_wr_idx   = '0;
   logic [31:0]          seg_wr_base  = '0;
   logic [31:0]          seg_wr_limit = '0;
   logic                 req_valid    = 1'b0;
   logic                 req_ready;
   agen_uop_u            req_uop      = '0;
   logic [TAG_W-1:0]     req_tag      = '0;
   logic [31:0]          req_base     = '0;
   logic [31:0]          req_index    = '0;
   logic [31:0]          req_disp     = '0;
   logic                 res_valid;
   logic                 res_ready;
   logic [31:0]          res_addr;
   logic                 res_write;
   logic                 res_seg_fault;
   logic [TAG_W-1:0]     res_tag;

   // Expected result for the request being presented
   logic                 exp_push  = 1'b0;
   logic [31:0]          exp_addr  = '0;
   logic                 exp_write = 1'b0;
   logic                 exp_fault = 1'b0;
   logic [TAG_W-1:0]     exp_tag   = '0;

   int                   pending;
   int                   mismatches;
   int                   other_errs;
   int                   file_errs = 0;
   int                   wd_limit  = 0;
   bit                   wd_armed  = 1'b0;
   string                lines [$];

   always #(CLK_PERIOD / 2) clk = ~clk;

   agen_top #(.FIFO_DEPTH(FIFO_DEPTH)) agen_top_i (
      .clk, .arst_n,
      .seg_wr_en, .seg_wr_idx, .seg_wr_base, .seg_wr_limit,
      .req_valid, .req_ready, .req_uop, .req_tag, .req_base, .req_index, .req_disp,
      .res_valid, .res_ready, .res_addr, .res_write, .res_seg_fault, .res_tag
   );

   agen_checker checker_i (
      .clk, .arst_n,
      .exp_push, .exp_addr, .exp_write, .exp_fault, .exp_tag,
      .res_valid, .res_ready, .res_addr, .res_write, .res_seg_fault, .res_tag,
      .pending, .mismatches, .other_errs
   );

   // Write lands on the next rising edge
   task automatic write_segment(input logic [SEG_IDX_W-1:0] idx, input logic [31:0] base,
                                input logic [31:0] limit);
      seg_wr_en    = 1'b1;
      seg_wr_idx   = idx;
      seg_wr_base  = base;
      seg_wr_limit = limit;
      @(negedge clk);
      seg_wr_en = 1'b0;
   endtask

   task automatic send_request(input logic [31:0] uop, input logic [TAG_W-1:0] tag,
                               input logic [31:0] base, input logic [31:0] index,
                               input logic [31:0] disp, input logic [31:0] e_addr,
                               input logic e_write, input logic e_fault);
      logic accepted;
      req_valid = 1'b1;
      req_uop   = uop;
      req_tag   = tag;
      req_base  = base;
      req_index = index;
      req_disp  = disp;
      exp_push  = 1'b1;
      exp_addr  = e_addr;
      exp_write = e_write;
      exp_fault = e_fault;
      exp_tag   = tag;
      // req_ready only moves on rising edges
      do begin
         accepted = req_ready;
         @(negedge clk);
         exp_push = 1'b0;
      end while (!accepted);
      req_valid = 1'b0;
   endtask

   // Random result back-pressure, ready about 70% of cycles
   initial begin
      void'($urandom(RAND_SEED));
      res_ready = 1'b0;
      forever begin
         @(negedge clk);
         res_ready = ($urandom % 100) < 70;
      end
   end

   initial begin
      int          fd;
      int          n;
      int          total;
      bit          bad_line;
      string       line;
      logic [31:0] f [8];
      fd = $fopen("tb/agen_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file tb/agen_vectors.txt");
         file_errs++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && (line[0] == "S" || line[0] == "R"))
               lines.push_back(line);
         end
         $fclose(fd);
      end
      wd_limit = lines.size() * 40 * CLK_PERIOD + RESET_CYC * CLK_PERIOD;
      wd_armed = 1'b1;
      repeat (RESET_CYC) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      foreach (lines[i]) begin
         line = lines[i];
         if (line[0] == "S") begin
            n = $sscanf(line, "S %h %h %h", f[0], f[1], f[2]);
            bad_line = n != 3;
            if (!bad_line)
               write_segment(f[0][SEG_IDX_W-1:0], f[1], f[2]);
         end else begin
            n = $sscanf(line, "R %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            bad_line = n != 8;
            if (!bad_line)
               send_request(f[0], f[1][TAG_W-1:0], f[2], f[3], f[4], f[5], f[6][0], f[7][0]);
         end
         if (bad_line) begin
            $display("Vector line could not be parsed: %s", line);
            file_errs++;
         end
      end
      wait (pending == 0);
      // Room for any stray extra result to show up
      repeat (20) @(negedge clk);
      total = mismatches + other_errs + file_errs + agen_top_i.sva_i.fail_cnt;
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatches, other_errs + file_errs, agen_top_i.sva_i.fail_cnt);
      if (total == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   initial begin
      wait (wd_armed);
      #(wd_limit);
      $display("Timeout after %0d ns with %0d results still outstanding", wd_limit, pending);
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatches, other_errs + file_errs + 1, agen_top_i.sva_i.fail_cnt);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: tb/agen_vectors.txt
# S seg_idx base limit
# R uop tag base index disp exp_addr exp_write exp_fault (all hex)
R 32000000 1 00001000 00000000 00000010 00001010 0 0
R 70800000 2 ffffff00 00000000 000000ff ffffffff 1 0
R a0000000 3 00002000 00000000 00000000 00002000 0 0
S 0 00010000 0000ffff
S 1 00100000 000fffff
S 2 00200000 0000ffff
S 3 80000000 ffffffff
S 4 fffff000 00000fff
R 12400000 4 00001000 00000004 00000020 00101024 0 0
R 16400000 5 00002000 00000010 00000008 00102028 0 0
R 09c00000 6 00000100 00000003 00000004 00010110 1 0
R 3e400000 7 00000010 00000100 00000001 80000811 0 0
R 3e000000 8 00000010 00000100 00000001 80000011 0 0
R 38400000 9 ffffff00 00000080 00000010 80000110 0 0
R 42000000 a 00000800 00000000 00000100 fffff900 0 0
R 31000000 b 80000000 00000000 00000010 00000010 0 0
R 02000000 c 0000fff0 00000000 0000000c 0001fffc 0 0
R 02000000 d 0000fff0 00000000 0000000d 0001fffd 0 1
R 01800000 e 0000ffff 00000000 00000000 0001ffff 1 1
R 32000000 f fffffffe 00000000 00000000 7ffffffe 0 1
R 31000000 0 ffffffff 00000000 00000000 7fffffff 0 1
R 42000000 1 00000f00 00000000 000000fc fffffffc 0 0
R 42000000 2 00000f00 00000000 000000fd fffffffd 0 1
R e0000000 3 00001000 00000000 00000000 00200ffc 1 0
R a0000000 4 00000ffc 12345678 00000040 00200ffc 0 0
R d0000000 5 00000800 00000000 00000000 002007fe 1 0
R 90000000 6 000007fe 00000000 00000000 002007fe 0 0
R c0000000 7 00000100 00000000 00000000 002000ff 1 0
R 80000000 8 000000ff 00000000 00000000 002000ff 0 0
R e0000000 9 00000000 00000000 00000000 001ffffc 1 1
R a0000000 a 0000fffe 00000000 00000000 0020fffe 0 1
S 2 00300000 000fffff
R a0000000 b 0000fffe 00000000 00000000 0030fffe 0 0
S 1 00400000 00000fff
R 12400000 c 00001000 00000004 00000020 00401024 0 1
R 12000000 d 00000ffc 00000000 00000000 00400ffc 0 0
S 1 00100000 000fffff
R 16400000 e 00002000 00000010 00000008 00102028 0 0
